//--- pkt_fifo_cfg.svh
// configuration macros for the packet FIFO: word size, buffer depth, counter width

`ifndef PKT_FIFO_CFG_SVH
`define PKT_FIFO_CFG_SVH

// ------------------------------
// datapath
// ------------------------------

// bytes per stream word
`define PF_DATA_BYTES 8

// ------------------------------
// buffer
// ------------------------------

// log2 of the word memory depth, 64 words
`define PF_DEPTH_LOG2 6

// ------------------------------
// statistics and flow control
// ------------------------------

// width of the packet counters and of the flow-control threshold
`define PF_CNT_WID 16

`endif

//--- pkt_fifo_pkg.sv
// packet FIFO package: shared vector typedefs and state machine encodings

`include "pkt_fifo_cfg.svh"

package pkt_fifo_pkg;

   // ------------------------------
   // datapath vectors
   // ------------------------------

   // one stream word
   typedef logic [`PF_DATA_BYTES*8-1:0] pf_data_t;

   // byte-valid mask, one bit per data byte
   typedef logic [`PF_DATA_BYTES-1:0] pf_keep_t;

   // ------------------------------
   // buffer bookkeeping
   // ------------------------------

   // word address into the buffer memory
   typedef logic [`PF_DEPTH_LOG2-1:0] pf_addr_t;

   // occupancy, one bit wider so a full buffer is representable
   typedef logic [`PF_DEPTH_LOG2:0] pf_occ_t;

   // counter value, also used for the flow-control threshold
   typedef logic [`PF_CNT_WID-1:0] pf_cnt_t;

   // ------------------------------
   // state machines
   // ------------------------------

   // ingress either stores the current packet or throws the rest of it away
   typedef enum logic {
      ING_PASS,
      ING_DROP
   } ingress_state_t;

   // egress knows whether the next transfer opens a packet
   typedef enum logic {
      EG_SOP,
      EG_BODY
   } egress_state_t;

endpackage

//--- pkt_ingress.sv
// pkt_ingress: input register stage and per-packet keep/drop decision

`timescale 1ns/1ps

`include "pkt_fifo_cfg.svh"

module pkt_ingress import pkt_fifo_pkg::*; (
   input  logic     axi4s_out,
   input  logic     rst_n,

   // valid-only input stream
   input  logic     in_valid,
   input  pf_data_t in_data,
   input  pf_keep_t in_keep,
   input  logic     in_last,
   input  logic     in_err,

   input  logic     drop_errored,

   // buffer write side
   input  logic     buf_full,
   output logic     wr_en,
   output pf_data_t wr_data,
   output pf_keep_t wr_keep,
   output logic     wr_last,
   output logic     commit,
   output logic     rewind,

   // event pulses for the statistics block
   output logic     pkt_in,
   output logic     drop_ovfl,
   output logic     drop_err
);

   logic           v_q;
   pf_data_t       data_q;
   pf_keep_t       keep_q;
   logic           last_q;
   logic           err_q;

   ingress_state_t state;

   logic           pass;
   logic           ovfl;
   logic           err_drop;

   // ------------------------------
   // input register
   // ------------------------------

   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         v_q <= 1'b0;
      end else begin
         v_q <= in_valid;
      end
   end

   // payload, only meaningful while v_q is set
   always_ff @(posedge axi4s_out) begin
      data_q <= in_data;
      keep_q <= in_keep;
      last_q <= in_last;
      err_q  <= in_err;
   end

   // ------------------------------
   // keep/drop decision
   // ------------------------------

   assign pass = v_q && (state == ING_PASS);

   // no room for this word, so the partial packet goes
   assign ovfl = pass && buf_full;

   // errored last word: skip the write and throw the packet out
   assign err_drop = pass && !buf_full && last_q && err_q && drop_errored;

   assign wr_en   = pass && !buf_full && !err_drop;
   assign commit  = wr_en && last_q;
   assign rewind  = ovfl || err_drop;

   assign wr_data = data_q;
   assign wr_keep = keep_q;
   assign wr_last = last_q;

   assign pkt_in    = commit;
   assign drop_ovfl = ovfl;
   assign drop_err  = err_drop;

   // ------------------------------
   // packet state
   // ------------------------------

   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         state <= ING_PASS;
      end else begin
         case (state)
            ING_PASS: begin
               // an overflow on the last word ends the packet right here
               if (ovfl && !last_q) begin
                  state <= ING_DROP;
               end
            end
            ING_DROP: begin
               if (v_q && last_q) begin
                  state <= ING_PASS;
               end
            end
            default: state <= ING_PASS;
         endcase
      end
   end

endmodule

//--- pkt_buffer.sv
// pkt_buffer: word memory with write, commit and read pointers, occupancy and flow control

`timescale 1ns/1ps

`include "pkt_fifo_cfg.svh"

module pkt_buffer import pkt_fifo_pkg::*; (
   input  logic     axi4s_out,
   input  logic     rst_n,

   // write side, driven by ingress
   input  logic     wr_en,
   input  pf_data_t wr_data,
   input  pf_keep_t wr_keep,
   input  logic     wr_last,
   input  logic     commit,
   input  logic     rewind,
   output logic     buf_full,

   // read side, drained by egress
   input  logic     rd_en,
   output pf_data_t rd_data,
   output pf_keep_t rd_keep,
   output logic     rd_last,
   output logic     rd_avail,

   // flow control
   input  pf_cnt_t  flow_ctl_thresh,
   output logic     flow_ctl
);

   localparam int DEPTH = 1 << `PF_DEPTH_LOG2;

   // one stored entry: data with its keep mask and last flag
   typedef struct packed {
      logic     last;
      pf_keep_t keep;
      pf_data_t data;
   } buf_word_t;

   buf_word_t mem [DEPTH];

   // pointers carry an extra wrap bit above the address
   pf_occ_t   wr_ptr;
   pf_occ_t   cmt_ptr;
   pf_occ_t   rd_ptr;

   pf_addr_t  wr_addr;
   pf_addr_t  rd_addr;

   pf_occ_t   occ;
   pf_cnt_t   occ_ext;
   buf_word_t rd_word;

   assign wr_addr = wr_ptr[`PF_DEPTH_LOG2-1:0];
   assign rd_addr = rd_ptr[`PF_DEPTH_LOG2-1:0];

   // ------------------------------
   // memory
   // ------------------------------

   always_ff @(posedge axi4s_out) begin
      if (wr_en) begin
         mem[wr_addr] <= '{last: wr_last, keep: wr_keep, data: wr_data};
      end
   end

   // word at the read pointer is always on the read port
   assign rd_word = mem[rd_addr];
   assign rd_data = rd_word.data;
   assign rd_keep = rd_word.keep;
   assign rd_last = rd_word.last;

   // ------------------------------
   // pointers
   // ------------------------------

   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         cmt_ptr <= '0;
         rd_ptr  <= '0;
      end else begin
         // rewind throws away everything written since the last commit
         if (rewind) begin
            wr_ptr <= cmt_ptr;
         end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end

         // commit comes with the last word, which is included
         if (commit) begin
            cmt_ptr <= wr_ptr + 1'b1;
         end

         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // only committed words may be read
   assign rd_avail = (cmt_ptr != rd_ptr);

   // ------------------------------
   // occupancy and flow control
   // ------------------------------

   // counts uncommitted words too
   assign occ      = wr_ptr - rd_ptr;
   assign buf_full = (occ == pf_occ_t'(DEPTH));
   assign occ_ext  = pf_cnt_t'(occ);

   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         flow_ctl <= 1'b0;
      end else begin
         flow_ctl <= (occ_ext > flow_ctl_thresh);
      end
   end

endmodule

//--- pkt_egress.sv
// pkt_egress: registered output stage with valid/ready and end-of-packet events

`timescale 1ns/1ps

`include "pkt_fifo_cfg.svh"

module pkt_egress import pkt_fifo_pkg::*; (
   input  logic     axi4s_out,
   input  logic     rst_n,

   // buffer read port
   input  logic     rd_avail,
   input  pf_data_t rd_data,
   input  pf_keep_t rd_keep,
   input  logic     rd_last,
   output logic     rd_en,

   // output stream
   output logic     out_valid,
   output pf_data_t out_data,
   output pf_keep_t out_keep,
   output logic     out_last,
   input  logic     out_ready,

   output logic     pkt_out
);

   logic          xfer;
   logic          load;

   assign xfer = out_valid && out_ready;

   // refill when the register is empty or emptying this cycle
   assign load  = rd_avail && (!out_valid || out_ready);
   assign rd_en = load;

   // ------------------------------
   // output register
   // ------------------------------

   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge axi4s_out) begin
      if (load) begin
         out_data <= rd_data;
         out_keep <= rd_keep;
         out_last <= rd_last;
      end
   end

   // ------------------------------
   // packet boundaries
   // ------------------------------

   // a packet leaves when its last word transfers
   assign pkt_out = xfer && out_last;

endmodule

//--- pkt_stats.sv
// pkt_stats: saturating packet counters for traffic in, out and dropped

`timescale 1ns/1ps

`include "pkt_fifo_cfg.svh"

module pkt_stats import pkt_fifo_pkg::*; (
   input  logic    axi4s_out,
   input  logic    rst_n,

   // one-cycle event pulses
   input  logic    pkt_in,
   input  logic    pkt_out,
   input  logic    drop_ovfl,
   input  logic    drop_err,

   output pf_cnt_t cnt_pkt_in,
   output pf_cnt_t cnt_pkt_out,
   output pf_cnt_t cnt_drop_ovfl,
   output pf_cnt_t cnt_drop_err
);

   // step by one, stick at all ones
   function automatic pf_cnt_t sat_inc(input pf_cnt_t cnt, input logic ev);
      sat_inc = (ev && (cnt != '1)) ? cnt + 1'b1 : cnt;
   endfunction

   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         cnt_pkt_in    <= '0;
         cnt_pkt_out   <= '0;
         cnt_drop_ovfl <= '0;
         cnt_drop_err  <= '0;
      end else begin
         cnt_pkt_in    <= sat_inc(cnt_pkt_in, pkt_in);
         cnt_pkt_out   <= sat_inc(cnt_pkt_out, pkt_out);
         cnt_drop_ovfl <= sat_inc(cnt_drop_ovfl, drop_ovfl);
         cnt_drop_err  <= sat_inc(cnt_drop_err, drop_err);
      end
   end

endmodule

//--- pkt_fifo.sv
// pkt_fifo: top level wiring ingress, buffer, egress and statistics

`timescale 1ns/1ps

`include "pkt_fifo_cfg.svh"

module pkt_fifo import pkt_fifo_pkg::*; (
   input  logic     axi4s_out,
   input  logic     rst_n,

   // input stream, no back-pressure
   input  logic     in_valid,
   input  pf_data_t in_data,
   input  pf_keep_t in_keep,
   input  logic     in_last,
   input  logic     in_err,

   input  logic     drop_errored,

   // output stream
   output logic     out_valid,
   output pf_data_t out_data,
   output pf_keep_t out_keep,
   output logic     out_last,
   input  logic     out_ready,

   input  pf_cnt_t  flow_ctl_thresh,
   output logic     flow_ctl,

   output pf_cnt_t  cnt_pkt_in,
   output pf_cnt_t  cnt_pkt_out,
   output pf_cnt_t  cnt_drop_ovfl,
   output pf_cnt_t  cnt_drop_err
);

   // ingress to buffer
   logic     wr_en;
   pf_data_t wr_data;
   pf_keep_t wr_keep;
   logic     wr_last;
   logic     commit;
   logic     rewind;
   logic     buf_full;

   // buffer to egress
   logic     rd_en;
   pf_data_t rd_data;
   pf_keep_t rd_keep;
   logic     rd_last;
   logic     rd_avail;

   // events
   logic     pkt_in;
   logic     pkt_out;
   logic     drop_ovfl;
   logic     drop_err;

   pkt_ingress ingress_i (
      .axi4s_out, .rst_n,
      .in_valid, .in_data, .in_keep, .in_last, .in_err,
      .drop_errored, .buf_full,
      .wr_en, .wr_data, .wr_keep, .wr_last, .commit, .rewind,
      .pkt_in, .drop_ovfl, .drop_err
   );

   pkt_buffer buffer_i (
      .axi4s_out, .rst_n,
      .wr_en, .wr_data, .wr_keep, .wr_last, .commit, .rewind, .buf_full,
      .rd_en, .rd_data, .rd_keep, .rd_last, .rd_avail,
      .flow_ctl_thresh, .flow_ctl
   );

   pkt_egress egress_i (
      .axi4s_out, .rst_n,
      .rd_avail, .rd_data, .rd_keep, .rd_last, .rd_en,
      .out_valid, .out_data, .out_keep, .out_last, .out_ready,
      .pkt_out
   );

   pkt_stats stats_i (
      .axi4s_out, .rst_n,
      .pkt_in, .pkt_out, .drop_ovfl, .drop_err,
      .cnt_pkt_in, .cnt_pkt_out, .cnt_drop_ovfl, .cnt_drop_err
   );

endmodule

//--- pkt_fifo_tb.sv
// pkt_fifo_tb: clock, reset, seeded random packets, expected-word queue, monitor and checks

`timescale 1ns/1ps

`include "pkt_fifo_cfg.svh"

module pkt_fifo_tb import pkt_fifo_pkg::*; ();

   localparam int DEPTH       = 1 << `PF_DEPTH_LOG2;
   localparam int MAX_LEN     = 12;
   localparam int T1_PKTS     = 200;
   localparam int T2_PKTS     = 24;
   localparam int T3_PKTS     = 40;
   localparam int FLOW_ROUNDS = 6;

   // worst-case word counts per test set the run limit
   localparam int WORDS_T1    = T1_PKTS * MAX_LEN;
   localparam int WORDS_T2    = T2_PKTS * MAX_LEN;
   localparam int WORDS_T3    = 2 * T3_PKTS * MAX_LEN;
   localparam int WORDS_T5    = FLOW_ROUNDS * (DEPTH + 1);
   localparam int CYCLE_LIMIT = (WORDS_T1 + WORDS_T2 + WORDS_T3 + WORDS_T5) * 4 + 2000;

   typedef struct packed {
      logic [31:0] id;
      logic        last;
      pf_keep_t    keep;
      pf_data_t    data;
   } exp_word_t;

   logic     axi4s_out;
   logic     rst_n;
   logic     in_valid;
   pf_data_t in_data;
   pf_keep_t in_keep;
   logic     in_last;
   logic     in_err;
   logic     drop_errored;
   logic     out_valid;
   pf_data_t out_data;
   pf_keep_t out_keep;
   logic     out_last;
   logic     out_ready;
   pf_cnt_t  flow_ctl_thresh;
   logic     flow_ctl;
   pf_cnt_t  cnt_pkt_in;
   pf_cnt_t  cnt_pkt_out;
   pf_cnt_t  cnt_drop_ovfl;
   pf_cnt_t  cnt_drop_err;

   // model state
   exp_word_t   exp_q[$];
   int unsigned kept_total;
   int unsigned sent_done;
   int unsigned checked_id;
   int          ovfl_drops;
   int          err_drops;
   int          errors;
   int          sop_errors;
   int          checks;
   int          tests;
   int          cycles;
   // 0 holds out_ready low, 1 high, 2 random
   int          ready_mode;

   pkt_fifo dut_i (
      .axi4s_out(axi4s_out), .rst_n(rst_n),
      .in_valid(in_valid), .in_data(in_data), .in_keep(in_keep),
      .in_last(in_last), .in_err(in_err), .drop_errored(drop_errored),
      .out_valid(out_valid), .out_data(out_data), .out_keep(out_keep),
      .out_last(out_last), .out_ready(out_ready),
      .flow_ctl_thresh(flow_ctl_thresh), .flow_ctl(flow_ctl),
      .cnt_pkt_in(cnt_pkt_in), .cnt_pkt_out(cnt_pkt_out),
      .cnt_drop_ovfl(cnt_drop_ovfl), .cnt_drop_err(cnt_drop_err)
   );

   // ------------------------------
   // clock, timeout, ready driver
   // ------------------------------

   initial begin
      axi4s_out = 1'b0;
      forever #20 axi4s_out = ~axi4s_out;
   end

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge axi4s_out);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
   end

   always @(negedge axi4s_out) begin
      if (ready_mode == 2) begin
         out_ready = 1'($urandom % 2);
      end else begin
         out_ready = (ready_mode == 1);
      end
   end

   // ------------------------------
   // helpers
   // ------------------------------

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge axi4s_out);
         in_valid = 1'b0;
         in_last  = 1'b0;
         in_err   = 1'b0;
      end
   endtask

   // mode change lands at a rising edge so the ready driver sees it cleanly
   task automatic set_ready(input int mode);
      @(posedge axi4s_out);
      ready_mode = mode;
   endtask

   task automatic send_packet(input int len, input bit err, input bit kept);
      pf_data_t  dw [DEPTH];
      pf_keep_t  kw [DEPTH];
      exp_word_t e;
      for (int w = 0; w < len; w++) begin
         dw[w] = {$urandom, $urandom};
         kw[w] = pf_keep_t'($urandom);
      end
      if (kept) begin
         kept_total++;
         for (int w = 0; w < len; w++) begin
            e.id   = kept_total;
            e.last = (w == len - 1);
            e.keep = kw[w];
            e.data = dw[w];
            exp_q.push_back(e);
         end
      end
      for (int w = 0; w < len; w++) begin
         @(negedge axi4s_out);
         in_valid = 1'b1;
         in_data  = dw[w];
         in_keep  = kw[w];
         in_last  = (w == len - 1);
         in_err   = err && (w == len - 1);
      end
      if (kept) begin
         sent_done = kept_total;
      end
   endtask

   // keep the words in flight within the buffer
   task automatic pace(input int len);
      while (exp_q.size() + len > DEPTH) begin
         idle(1);
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0 || out_valid) begin
         idle(1);
      end
   endtask

   task automatic report_test(input string name, input int errs);
      tests++;
      if (errs == 0) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         $display("test %0d %s: %0d errors", tests, name, errs);
      end
   endtask

   function automatic int random_len(input int lo, input int hi);
      return lo + int'($urandom % (hi - lo + 1));
   endfunction

   // ------------------------------
   // output monitor
   // ------------------------------

   always @(posedge axi4s_out) begin
      if (rst_n && out_valid) begin
         if (exp_q.size() == 0) begin
            if (out_ready) begin
               errors++;
               $display("output word transferred while no packet was expected");
            end
         end else begin
            // first sighting of a packet must follow its last input word
            if (exp_q[0].id != checked_id) begin
               checked_id = exp_q[0].id;
               if (exp_q[0].id > sent_done) begin
                  sop_errors++;
                  $display("packet %0d left the FIFO before its last word came in",
                           exp_q[0].id);
               end
            end
            if (out_ready) begin
               check_value("out_data", out_data, exp_q[0].data);
               check_value("out_keep", 64'(out_keep), 64'(exp_q[0].keep));
               check_value("out_last", 64'(out_last), 64'(exp_q[0].last));
               void'(exp_q.pop_front());
            end
         end
      end
   end

   // ------------------------------
   // test sequence
   // ------------------------------

   initial begin
      int len;
      int buf_words;
      int n;
      int thr;
      int errs_before;
      bit err;

      void'($urandom(32'hfdeb));
      rst_n           = 1'b0;
      in_valid        = 1'b0;
      in_data         = '0;
      in_keep         = '0;
      in_last         = 1'b0;
      in_err          = 1'b0;
      drop_errored    = 1'b0;
      out_ready       = 1'b0;
      flow_ctl_thresh = '0;
      ready_mode      = 0;
      kept_total      = 0;
      sent_done       = 0;
      checked_id      = 0;
      ovfl_drops      = 0;
      err_drops       = 0;
      errors          = 0;
      sop_errors      = 0;
      checks          = 0;
      tests           = 0;
      repeat (16) @(negedge axi4s_out);
      rst_n = 1'b1;
      idle(4);

      // random traffic with random back-pressure, never overflowing
      errs_before = errors;
      set_ready(2);
      for (int p = 0; p < T1_PKTS; p++) begin
         len = random_len(1, MAX_LEN);
         pace(len);
         send_packet(len, 1'b0, 1'b1);
         idle(int'($urandom % 2));
      end
      idle(1);
      wait_drain();
      report_test("random traffic", errors - errs_before);

      // overflow: the egress register holds one word outside the buffer
      errs_before = errors;
      set_ready(0);
      for (int p = 0; p < T2_PKTS; p++) begin
         len = random_len(4, MAX_LEN);
         buf_words = (exp_q.size() > 0) ? exp_q.size() - 1 : 0;
         if (buf_words + len <= DEPTH) begin
            send_packet(len, 1'b0, 1'b1);
         end else begin
            ovfl_drops++;
            send_packet(len, 1'b0, 1'b0);
         end
         idle(int'($urandom % 2));
      end
      idle(2);
      set_ready(1);
      wait_drain();
      check_value("cnt_drop_ovfl", 64'(cnt_drop_ovfl), 64'(ovfl_drops));
      report_test("overflow discard", errors - errs_before);

      // errored packets, first dropped, then forwarded
      errs_before = errors;
      set_ready(2);
      for (int half = 0; half < 2; half++) begin
         idle(1);
         drop_errored = (half == 0);
         for (int p = 0; p < T3_PKTS; p++) begin
            len = random_len(1, MAX_LEN);
            err = (($urandom % 3) == 0);
            pace(len);
            if (err && drop_errored) begin
               err_drops++;
            end
            send_packet(len, err, !(err && drop_errored));
            idle(int'($urandom % 2));
         end
         idle(1);
         wait_drain();
      end
      check_value("cnt_drop_err", 64'(cnt_drop_err), 64'(err_drops));
      report_test("errored packets", errors - errs_before);

      report_test("whole-packet forwarding", sop_errors);

      // flow control: a primer word parks in egress, then n words fill the buffer
      errs_before = errors;
      set_ready(0);
      for (int r = 0; r < FLOW_ROUNDS; r++) begin
         n = random_len(1, DEPTH);
         case (r % 3)
            0:       thr = n - 1;
            1:       thr = n;
            default: thr = int'($urandom % (DEPTH + 8));
         endcase
         idle(1);
         flow_ctl_thresh = pf_cnt_t'(thr);
         send_packet(1, 1'b0, 1'b1);
         idle(1);
         while (!out_valid) begin
            idle(1);
         end
         send_packet(n, 1'b0, 1'b1);
         idle(3);
         check_value("flow_ctl", 64'(flow_ctl), 64'(n > thr));
         set_ready(1);
         wait_drain();
         set_ready(0);
      end
      report_test("flow control", errors - errs_before);

      // packet counters against the model's kept total
      errs_before = errors;
      idle(2);
      check_value("cnt_pkt_in", 64'(cnt_pkt_in), 64'(kept_total));
      check_value("cnt_pkt_out", 64'(cnt_pkt_out), 64'(kept_total));
      report_test("counters", errors - errs_before);

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors + sop_errors);
      if (errors + sop_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- pkt_fifo.f
+incdir+.
pkt_fifo_pkg.sv
pkt_ingress.sv
pkt_buffer.sv
pkt_egress.sv
pkt_stats.sv
pkt_fifo.sv
pkt_fifo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the packet FIFO testbench with Verilator

set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
   --top-module pkt_fifo_tb \
   -f pkt_fifo.f \
   -o pkt_fifo_sim

./obj_dir/pkt_fifo_sim | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
   echo "simulation reported failures, see $LOG"
   exit 1
fi

echo "simulation log in $LOG"
